// ==== verilog/intExecPkg.sv ====
//============================================================
// Shared widths, encodings and types of the integer pipeline
// Opcodes 14 and 15 are unused and decode as an add
// Condition code 7 is unused and evaluates as true
//============================================================
package intExecPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 32;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [addrWidth-1:0] addrT;
    typedef logic [3:0]           opCodeT;
    typedef logic [2:0]           condT;
    typedef logic [1:0]           opClassT;
    typedef logic [4:0]           shiftAmtT;

    // Link and fall-through offset
    localparam int unsigned insnBytes = 4;

    // ALU operations
    localparam opCodeT opAdd  = 4'd0;
    localparam opCodeT opSub  = 4'd1;
    localparam opCodeT opAnd  = 4'd2;
    localparam opCodeT opOr   = 4'd3;
    localparam opCodeT opXor  = 4'd4;
    localparam opCodeT opSlt  = 4'd5;
    localparam opCodeT opSltu = 4'd6;

    // Shifts
    localparam opCodeT opSll  = 4'd7;
    localparam opCodeT opSrl  = 4'd8;
    localparam opCodeT opSra  = 4'd9;

    // Select, branch and jumps
    localparam opCodeT opSel  = 4'd10;
    localparam opCodeT opBr   = 4'd11;
    localparam opCodeT opJal  = 4'd12;
    localparam opCodeT opJalr = 4'd13;

    // Condition codes
    localparam condT condEq  = 3'd0;
    localparam condT condNe  = 3'd1;
    localparam condT condLt  = 3'd2;
    localparam condT condLtu = 3'd3;
    localparam condT condGe  = 3'd4;
    localparam condT condGeu = 3'd5;
    localparam condT condAl  = 3'd6;

    // Op classes
    localparam opClassT classAlu    = 2'd0;
    localparam opClassT classShift  = 2'd1;
    localparam opClassT classSel    = 2'd2;
    localparam opClassT classBranch = 2'd3;

endpackage

// ==== verilog/stageIfs.sv ====
//============================================================
// Stage links with a valid/ready handshake
// Payload must hold while valid is high and ready is low
//============================================================
`timescale 1ns/1ns

// Decoder to execute stage
interface decodedOpIf;
    import intExecPkg::*;

    logic    valid;
    logic    ready;
    opCodeT  opCode;
    opClassT opClass;
    condT    cond;
    addrT    pc;
    dataT    opA;
    dataT    opB;
    dataT    imm;
    logic    predTaken;
    addrT    predTarget;

    modport producer (output valid, opCode, opClass, cond, pc, opA, opB, imm,
                      predTaken, predTarget, input ready);
    modport consumer (input valid, opCode, opClass, cond, pc, opA, opB, imm,
                      predTaken, predTarget, output ready);
endinterface

// Execute stage to result stage
interface execResultIf;
    import intExecPkg::*;

    logic valid;
    logic ready;
    dataT data;
    logic isBranch;
    logic taken;
    addrT nextPc;
    logic predTaken;
    addrT predTarget;

    modport producer (output valid, data, isBranch, taken, nextPc, predTaken,
                      predTarget, input ready);
    modport consumer (input valid, data, isBranch, taken, nextPc, predTaken,
                      predTarget, output ready);
endinterface

// ==== verilog/intOpDecoder.sv ====
//============================================================
// Decode stage with a single slot
// Unknown opcodes become an add of class ALU
// Branches always compare srcB, whatever useImm says
//============================================================
`timescale 1ns/1ns

module intOpDecoder (
    input  logic                clk,
    input  logic                rstN,
    input  logic                flush,
    input  logic                inValid,
    output logic                inReady,
    input  intExecPkg::opCodeT  opCode,
    input  intExecPkg::condT    cond,
    input  logic                useImm,
    input  intExecPkg::addrT    pc,
    input  intExecPkg::dataT    srcA,
    input  intExecPkg::dataT    srcB,
    input  intExecPkg::dataT    imm,
    input  logic                predTaken,
    input  intExecPkg::addrT    predTarget,
    decodedOpIf.producer        dec
);
    import intExecPkg::*;

    opCodeT  decOpCode;
    opClassT decClass;
    dataT    decOpB;

    always_comb begin
        decOpCode = opCode;
        case (opCode)
            opAdd, opSub, opAnd, opOr, opXor, opSlt, opSltu: decClass = classAlu;
            opSll, opSrl, opSra:                             decClass = classShift;
            opSel:                                           decClass = classSel;
            opBr, opJal, opJalr:                             decClass = classBranch;
            default: begin
                decClass  = classAlu;
                decOpCode = opAdd;
            end
        endcase
    end

    assign decOpB  = (useImm && decClass != classBranch) ? imm : srcB;

    // Slot frees up when empty or when execute takes it this cycle
    assign inReady = !dec.valid || dec.ready;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            dec.valid <= 1'b0;
        end else if (inReady) begin
            dec.valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            dec.opCode     <= decOpCode;
            dec.opClass    <= decClass;
            dec.cond       <= cond;
            dec.pc         <= pc;
            dec.opA        <= srcA;
            dec.opB        <= decOpB;
            dec.imm        <= imm;
            dec.predTaken  <= predTaken;
            dec.predTarget <= predTarget;
        end
    end

endmodule

// ==== verilog/intAlu.sv ====
//============================================================
// Combinational ALU and barrel shifter
// Shift amount is the low 5 bits of b
//============================================================
`timescale 1ns/1ns

module intAlu (
    input  intExecPkg::opCodeT opCode,
    input  intExecPkg::dataT   a,
    input  intExecPkg::dataT   b,
    output intExecPkg::dataT   y
);
    import intExecPkg::*;

    shiftAmtT shiftAmt;

    assign shiftAmt = shiftAmtT'(b);

    always_comb begin
        case (opCode)
            opAdd:  y = a + b;
            opSub:  y = a - b;
            opAnd:  y = a & b;
            opOr:   y = a | b;
            opXor:  y = a ^ b;
            opSlt:  y = dataT'($signed(a) < $signed(b));
            opSltu: y = dataT'(a < b);
            opSll:  y = a << shiftAmt;
            opSrl:  y = a >> shiftAmt;
            // Sign bit fills from the left
            opSra:  y = dataT'($signed(a) >>> shiftAmt);
            default: y = a + b;
        endcase
    end

endmodule

// ==== verilog/branchResolver.sv ====
//============================================================
// Condition check, branch target and next PC
// Also evaluates the condition for conditional select
//============================================================
`timescale 1ns/1ns

module branchResolver (
    input  intExecPkg::opCodeT opCode,
    input  intExecPkg::condT   cond,
    input  intExecPkg::addrT   pc,
    input  intExecPkg::dataT   a,
    input  intExecPkg::dataT   b,
    input  intExecPkg::dataT   imm,
    output logic               condTrue,
    output logic               taken,
    output intExecPkg::addrT   nextPc,
    output intExecPkg::dataT   link
);
    import intExecPkg::*;

    logic isJump;
    addrT target;
    addrT fallThrough;

    always_comb begin
        case (cond)
            condEq:  condTrue = (a == b);
            condNe:  condTrue = (a != b);
            condLt:  condTrue = ($signed(a) < $signed(b));
            condLtu: condTrue = (a < b);
            condGe:  condTrue = ($signed(a) >= $signed(b));
            condGeu: condTrue = (a >= b);
            condAl:  condTrue = 1'b1;
            // Spare code counts as true
            default: condTrue = 1'b1;
        endcase
    end

    assign isJump      = (opCode == opJal) || (opCode == opJalr);
    assign taken       = ((opCode == opBr) && condTrue) || isJump;
    assign fallThrough = pc + addrT'(insnBytes);
    assign link        = dataT'(fallThrough);

    // Register-indirect target drops bit 0
    assign target = (opCode == opJalr) ? (addrT'(a + imm) & ~addrT'(1))
                                       : (pc + addrT'(imm));

    assign nextPc = taken ? target : fallThrough;

endmodule

// ==== verilog/intExecStage.sv ====
//============================================================
// Execute stage with a single slot
// Result is the ALU output, the selected operand or the link
//============================================================
`timescale 1ns/1ns

module intExecStage (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    decodedOpIf.consumer  dec,
    execResultIf.producer res
);
    import intExecPkg::*;

    dataT aluY;
    dataT link;
    dataT resultData;
    logic condTrue;
    logic taken;
    addrT nextPc;

    intAlu alu (
        .opCode (dec.opCode),
        .a      (dec.opA),
        .b      (dec.opB),
        .y      (aluY)
    );

    branchResolver resolver (
        .opCode   (dec.opCode),
        .cond     (dec.cond),
        .pc       (dec.pc),
        .a        (dec.opA),
        .b        (dec.opB),
        .imm      (dec.imm),
        .condTrue (condTrue),
        .taken    (taken),
        .nextPc   (nextPc),
        .link     (link)
    );

    always_comb begin
        case (dec.opClass)
            classAlu, classShift: resultData = aluY;
            classSel:             resultData = condTrue ? dec.opA : dec.opB;
            classBranch:          resultData = link;
            default:              resultData = aluY;
        endcase
    end

    assign dec.ready = !res.valid || res.ready;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            res.valid <= 1'b0;
        end else if (dec.ready) begin
            res.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid && dec.ready) begin
            res.data       <= resultData;
            res.isBranch   <= (dec.opClass == classBranch);
            res.taken      <= taken;
            res.nextPc     <= nextPc;
            res.predTaken  <= dec.predTaken;
            res.predTarget <= dec.predTarget;
        end
    end

endmodule

// ==== verilog/intResultStage.sv ====
//============================================================
// Result stage with misprediction check
// Target mismatch only matters when the op is taken
//============================================================
`timescale 1ns/1ns

module intResultStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              flush,
    execResultIf.consumer     res,
    output logic              outValid,
    input  logic              outReady,
    output intExecPkg::dataT  outData,
    output logic              outIsBranch,
    output logic              outTaken,
    output intExecPkg::addrT  outNextPc,
    output logic              outMispredict
);
    logic mispredict;

    assign mispredict = res.isBranch &&
                        ((res.predTaken != res.taken) ||
                         (res.taken && res.predTarget != res.nextPc));

    assign res.ready = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            outValid <= 1'b0;
        end else if (res.ready) begin
            outValid <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid && res.ready) begin
            outData       <= res.data;
            outIsBranch   <= res.isBranch;
            outTaken      <= res.taken;
            outNextPc     <= res.nextPc;
            outMispredict <= mispredict;
        end
    end

endmodule

// ==== verilog/intExecTop.sv ====
//============================================================
// Three-stage integer execution pipeline
// Latency is three cycles, one op per cycle
// Operands must arrive already read
//============================================================
`timescale 1ns/1ns

module intExecTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               flush,
    input  logic               inValid,
    output logic               inReady,
    input  intExecPkg::opCodeT opCode,
    input  intExecPkg::condT   cond,
    input  logic               useImm,
    input  intExecPkg::addrT   pc,
    input  intExecPkg::dataT   srcA,
    input  intExecPkg::dataT   srcB,
    input  intExecPkg::dataT   imm,
    input  logic               predTaken,
    input  intExecPkg::addrT   predTarget,
    output logic               outValid,
    input  logic               outReady,
    output intExecPkg::dataT   outData,
    output logic               outIsBranch,
    output logic               outTaken,
    output intExecPkg::addrT   outNextPc,
    output logic               outMispredict
);
    decodedOpIf  decBus ();
    execResultIf resBus ();

    intOpDecoder decoder (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .inValid    (inValid),
        .inReady    (inReady),
        .opCode     (opCode),
        .cond       (cond),
        .useImm     (useImm),
        .pc         (pc),
        .srcA       (srcA),
        .srcB       (srcB),
        .imm        (imm),
        .predTaken  (predTaken),
        .predTarget (predTarget),
        .dec        (decBus.producer)
    );

    intExecStage execStage (
        .clk   (clk),
        .rstN  (rstN),
        .flush (flush),
        .dec   (decBus.consumer),
        .res   (resBus.producer)
    );

    intResultStage resultStage (
        .clk           (clk),
        .rstN          (rstN),
        .flush         (flush),
        .res           (resBus.consumer),
        .outValid      (outValid),
        .outReady      (outReady),
        .outData       (outData),
        .outIsBranch   (outIsBranch),
        .outTaken      (outTaken),
        .outNextPc     (outNextPc),
        .outMispredict (outMispredict)
    );

endmodule

// ==== sim/intExecTb.sv ====
//============================================================
// Table-driven testbench for the integer execution pipeline
// Expected results come from a reference model of the op rules
// Stalls forever are caught by a cycle-count watchdog
//============================================================
`timescale 1ns/1ns

module intExecTb;
    import intExecPkg::*;

    typedef struct packed {
        dataT data;
        logic isBranch;
        logic taken;
        addrT nextPc;
        logic mispredict;
    } expT;

    logic clk = 1'b0;
    logic rstN, flush, inValid, inReady, useImm, predTaken;
    logic outValid, outReady, outIsBranch, outTaken, outMispredict;
    opCodeT opCode;
    condT cond;
    addrT pc, predTarget, outNextPc;
    dataT srcA, srcB, imm, outData;

    // Stimulus table, one entry per op
    opCodeT tOp[$];
    condT tCond[$];
    logic tUseImm[$], tPredTaken[$];
    addrT tPc[$], tPredTarget[$];
    dataT tSrcA[$], tSrcB[$], tImm[$];

    expT pending[$];
    int numOps = 0, curIdx = 0, cycleCnt = 0, lastAccept = 0, lastDeliver = 0;
    int valErrors = 0, otherErrors = 0, gap;
    logic randReady = 1'b0;

    intExecTop uut (.*);

    initial forever #10 clk = ~clk;

    function automatic logic condHolds(input condT c, input dataT a, input dataT b);
        logic sLt;
        // Differing sign bits decide a signed compare on their own
        sLt = (a[31] != b[31]) ? a[31] : (a < b);
        case (c)
            condEq:  return a == b;
            condNe:  return a != b;
            condLt:  return sLt;
            condLtu: return a < b;
            condGe:  return !sLt;
            condGeu: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    function automatic expT refModel(input int i);
        expT e;
        dataT a, b;
        shiftAmtT s;
        logic isJump, ct;
        addrT tgt;
        a = tSrcA[i];
        isJump = (tOp[i] == opJal) || (tOp[i] == opJalr);
        e.isBranch = isJump || (tOp[i] == opBr);
        b = (tUseImm[i] && !e.isBranch) ? tImm[i] : tSrcB[i];
        s = b[4:0];
        ct = condHolds(tCond[i], a, b);
        case (tOp[i])
            opSub:  e.data = a - b;
            opAnd:  e.data = a & b;
            opOr:   e.data = a | b;
            opXor:  e.data = a ^ b;
            opSlt:  e.data = {31'b0, condHolds(condLt, a, b)};
            opSltu: e.data = {31'b0, condHolds(condLtu, a, b)};
            opSll:  e.data = a << s;
            opSrl:  e.data = a >> s;
            opSra:  e.data = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
            opSel:  e.data = ct ? a : b;
            opBr, opJal, opJalr: e.data = tPc[i] + 32'd4;
            default: e.data = a + b;
        endcase
        e.taken = isJump || (tOp[i] == opBr && ct);
        tgt = (tOp[i] == opJalr) ? ((a + tImm[i]) & ~32'h1) : (tPc[i] + tImm[i]);
        e.nextPc = e.taken ? tgt : tPc[i] + 32'd4;
        e.mispredict = e.isBranch && ((tPredTaken[i] != e.taken) ||
                       (e.taken && tPredTarget[i] != e.nextPc));
        return e;
    endfunction

    task automatic addOp(input opCodeT op, input condT c, input logic ui, input addrT p,
                         input dataT a, input dataT b, input dataT im,
                         input logic pt, input addrT ptg);
        tOp.push_back(op);
        tCond.push_back(c);
        tUseImm.push_back(ui);
        tPc.push_back(p);
        tSrcA.push_back(a);
        tSrcB.push_back(b);
        tImm.push_back(im);
        tPredTaken.push_back(pt);
        tPredTarget.push_back(ptg);
    endtask

    task automatic buildTable();
        dataT va [3] = '{32'h8000_0f0f, 32'hffff_fffe, 32'h0000_0001};
        dataT vb [3] = '{32'h0000_0024, 32'h7fff_ffff, 32'hffff_ffff};
        addrT p;
        // ALU and shift ops, then spare opcode 14 which must act as add
        for (int op = 0; op < 11; op++) begin
            for (int k = 0; k < 3; k++) begin
                p = 32'h1000 + 32'(4 * tOp.size());
                addOp(opCodeT'(op == 10 ? 14 : op), condAl, k == 2, p, va[k],
                      (k == 2) ? 32'h5555_5555 : vb[k], vb[k], 1'b0, 32'h0);
            end
        end
        // Select over every condition code, spare code 7 included
        for (int c = 0; c < 8; c++) begin
            p = 32'h1800 + 32'(c * 16);
            addOp(opSel, condT'(c), 1'b0, p, 32'h8000_0000, 32'h1, 32'h0, 1'b0, 32'h0);
            addOp(opSel, condT'(c), 1'b1, p + 8, 32'h7, 32'h1234, 32'h7, 1'b0, 32'h0);
        end
        // Second branch of each pair predicts a wrong target
        for (int c = 0; c < 7; c++) begin
            p = 32'h2000 + 32'(c * 16);
            addOp(opBr, condT'(c), 1'b0, p, 32'h8000_0000, 32'h1, 32'h40,
                  c % 2 == 1, p + 32'h40);
            addOp(opBr, condT'(c), 1'b1, p + 8, 32'h5, 32'h5, 32'h40,
                  c % 2 == 0, p + 32'h4c);
        end
        addOp(opJal, condEq, 1'b0, 32'h3000, 32'h0, 32'h0, 32'h100, 1'b1, 32'h3100);
        addOp(opJal, condEq, 1'b0, 32'h3010, 32'h0, 32'h0, 32'h100, 1'b0, 32'h3110);
        addOp(opJal, condEq, 1'b0, 32'h3020, 32'h0, 32'h0, 32'hffff_fff0, 1'b1, 32'h3020);
        addOp(opJalr, condNe, 1'b0, 32'h3030, 32'h5001, 32'h0, 32'h10, 1'b1, 32'h5010);
        addOp(opJalr, condEq, 1'b1, 32'h3040, 32'h5001, 32'h0, 32'h10, 1'b1, 32'h5011);
        addOp(opJalr, condLt, 1'b0, 32'h3050, 32'h6000, 32'h0, 32'hffff_fffd, 1'b0, 32'h0);
        numOps = tOp.size();
    endtask

    task automatic driveInputs(input int i);
        curIdx = i;
        opCode = tOp[i];
        cond = tCond[i];
        useImm = tUseImm[i];
        pc = tPc[i];
        srcA = tSrcA[i];
        srcB = tSrcB[i];
        imm = tImm[i];
        predTaken = tPredTaken[i];
        predTarget = tPredTarget[i];
    endtask

    // Returns on the clock edge that accepts the op
    task automatic sendOp(input int i);
        @(negedge clk);
        driveInputs(i);
        inValid = 1'b1;
        @(posedge clk);
        while (!inReady) @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        inValid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            valErrors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin : scoreboard
        expT e;
        cycleCnt++;
        if (rstN && outValid && outReady) begin
            assert (pending.size() != 0) else begin
                otherErrors++;
                $display("A result came out with no op pending at cycle %0d", cycleCnt);
            end
            if (pending.size() != 0) begin
                e = pending.pop_front();
                lastDeliver = cycleCnt;
                checkValue("outData", outData, e.data);
                checkValue("outIsBranch", 32'(outIsBranch), 32'(e.isBranch));
                checkValue("outTaken", 32'(outTaken), 32'(e.taken));
                checkValue("outNextPc", outNextPc, e.nextPc);
                checkValue("outMispredict", 32'(outMispredict), 32'(e.mispredict));
            end
        end
        // Flush drops every op in flight and the one offered with it
        if (flush) begin
            pending.delete();
        end else if (rstN && inValid && inReady) begin
            pending.push_back(refModel(curIdx));
            lastAccept = cycleCnt;
        end
    end

    always @(negedge clk) begin
        if (randReady) outReady = ($urandom % 4) != 0;
    end

    initial begin
        wait (numOps != 0);
        repeat (numOps * 40 + 200) @(posedge clk);
        $display("Timeout: the pipeline stopped delivering results");
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(32'he66));
        {rstN, flush, inValid, useImm, predTaken, outReady} = 6'b000001;
        {opCode, cond, pc, srcA, srcB, imm, predTarget} = '0;
        buildTable();
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        assert (!outValid && inReady) else begin
            otherErrors++;
            $display("Pipeline is not idle and ready after reset");
        end
        // Back to back with the output always ready
        for (int i = 0; i < numOps; i++) sendOp(i);
        drain();
        // Random input gaps and output stalls
        randReady = 1'b1;
        for (int i = 0; i < numOps; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                @(negedge clk);
                inValid = 1'b0;
            end
            sendOp(i);
        end
        @(negedge clk);
        inValid = 1'b0;
        randReady = 1'b0;
        @(negedge clk);
        outReady = 1'b1;
        drain();
        // Latency after an idle gap, acceptance edge to delivery edge
        repeat (3) @(negedge clk);
        sendOp(0);
        drain();
        assert (lastDeliver - lastAccept == 3) else begin
            otherErrors++;
            $display("First result took %0d cycles instead of 3", lastDeliver - lastAccept);
        end
        // Flush with two ops stalled and a third offered in the flush cycle
        @(negedge clk);
        outReady = 1'b0;
        sendOp(0);
        sendOp(1);
        @(negedge clk);
        driveInputs(2);
        flush = 1'b1;
        @(negedge clk);
        {flush, inValid, outReady} = 3'b001;
        assert (!outValid) else begin
            otherErrors++;
            $display("Output still valid after the flush");
        end
        for (int i = 3; i < 8; i++) sendOp(i);
        drain();
        repeat (4) @(negedge clk);
        $display("Checks done: %0d value errors, %0d other errors", valErrors, otherErrors);
        if (valErrors == 0 && otherErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/intExecPkg.sv
verilog/stageIfs.sv
verilog/intOpDecoder.sv
verilog/intAlu.sv
verilog/branchResolver.sv
verilog/intExecStage.sv
verilog/intResultStage.sv
verilog/intExecTop.sv
sim/intExecTb.sv

// ==== Bender.yml ====
package:
  name: int_exec_pipe

sources:
  - target: rtl
    files:
      - verilog/intExecPkg.sv
      - verilog/stageIfs.sv
      - verilog/intOpDecoder.sv
      - verilog/intAlu.sv
      - verilog/branchResolver.sv
      - verilog/intExecStage.sv
      - verilog/intResultStage.sv
      - verilog/intExecTop.sv
  - target: sim
    files:
      - sim/intExecTb.sv
